// File: src/memMapPkg.sv
`default_nettype none

package memMapPkg;

  // Byte address space of the data memory
  localparam int AddrWidth = 10;
  localparam int MemDepth  = 1024;

  typedef logic [AddrWidth-1:0] addrT;

  // Stack pointer value for an empty stack
  localparam logic [31:0] EmptySp = 32'hffff_ffff;

  // Default stack regions, inclusive on both ends
  localparam logic [31:0] DefUserStackStart = 32'd101;
  localparam logic [31:0] DefUserStackEnd   = 32'd106;
  localparam logic [31:0] DefPrivStackStart = 32'd107;
  localparam logic [31:0] DefPrivStackEnd   = 32'd112;

endpackage

`default_nettype wire

// File: src/accessPkg.sv
`default_nettype none

package accessPkg;

  typedef enum logic [2:0] {
    opNop,
    opPush,
    opPop,
    opLoad,
    opStore
  } opT;

  typedef enum logic [1:0] {
    size1,
    size2,
    size4
  } sizeT;

  typedef enum logic [1:0] {
    stOk,
    stOverflow,
    stUnderflow
  } statusT;

  // Host request, 48 bits
  typedef struct packed {
    opT               op;
    sizeT             size;
    logic             priv;   // Selects privileged stack
    memMapPkg::addrT  addr;
    logic [31:0]      data;
  } accessReqT;

  // Response to host, 37 bits
  typedef struct packed {
    opT          op;
    statusT      status;
    logic [31:0] data;
  } accessRspT;

  // What the handler asks of memory and pointer bank
  typedef struct packed {
    memMapPkg::addrT [3:0] lanes;
    logic [3:0]            laneEn;
    logic                  wrEn;
    logic [31:0]           nextSp;
    logic                  spWrite;
    statusT                status;
  } addrPlanT;

endpackage

`default_nettype wire

// File: src/creditFifo.sv
`timescale 1ns/1ps
`default_nettype none

module creditFifo #(
  parameter type itemT = logic [7:0],
  parameter int  Depth = 4,
  parameter bit  Gated = 1'b0  // Output held back by credit count
) (
  input  wire                          clk,
  input  wire                          rstN,
  input  wire                          pushValid,
  input  wire itemT                    pushItem,
  input  wire                          popReady,
  output logic                         popValid,
  output itemT                         popItem,
  output logic [$clog2(Depth+1)-1:0]   freeSlots,
  input  wire                          creditIn,
  output logic                         creditOut
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  itemT                store [Depth];
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CntWidth-1:0] count;
  logic [15:0]         credits;  // Granted but not yet spent
  logic                doPop;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
    nextPtr = (p == PtrWidth'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign popValid  = (count != '0) && (!Gated || credits != '0);
  assign doPop     = popValid && popReady;
  assign popItem   = store[rdPtr];
  assign freeSlots = CntWidth'(Depth) - count;
  assign creditOut = doPop;  // One credit back per released entry

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      credits <= '0;
    end else begin
      if (pushValid) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      count <= count + CntWidth'(pushValid) - CntWidth'(doPop);
      if (Gated) credits <= credits + 16'(creditIn) - 16'(doPop);
    end
  end

  always_ff @(posedge clk) begin
    if (pushValid) store[wrPtr] <= pushItem;
  end

  // Producer must hold a credit, so the queue is never overrun
  noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    pushValid |-> count != CntWidth'(Depth))
    else $error("creditFifo: push into full queue");

  // Consumer only takes what is offered
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
    (!Gated && popReady) |-> popValid)
    else $error("creditFifo: pop from empty queue");

endmodule

`default_nettype wire

// File: src/memoryAddressHandler.sv
`timescale 1ns/1ps
`default_nettype none

module memoryAddressHandler #(
  parameter logic [31:0] UserStackStart = memMapPkg::DefUserStackStart,
  parameter logic [31:0] UserStackEnd   = memMapPkg::DefUserStackEnd,
  parameter logic [31:0] PrivStackStart = memMapPkg::DefPrivStackStart,
  parameter logic [31:0] PrivStackEnd   = memMapPkg::DefPrivStackEnd
) (
  input  wire accessPkg::accessReqT req,
  input  wire [31:0]                sp,
  output accessPkg::addrPlanT       plan
);

  import memMapPkg::*;
  import accessPkg::*;

  logic [31:0] regStart;
  logic [31:0] regEnd;
  logic [31:0] spDec;
  logic        lanesClash;

  // Region of the active mode
  assign regStart = req.priv ? PrivStackStart : UserStackStart;
  assign regEnd   = req.priv ? PrivStackEnd : UserStackEnd;
  assign spDec    = sp - 32'd1;

  always_comb begin
    plan        = '0;
    plan.nextSp = sp;
    plan.status = stOk;
    // Byte k sits below the base address, wrapping at zero
    for (int k = 0; k < 4; k++) begin
      plan.lanes[k] = req.addr - addrT'(k);
    end

    case (req.op)
      opPush: begin
        if (sp == EmptySp) begin  // First item goes to the top
          plan.lanes[0] = regEnd[AddrWidth-1:0];
          plan.laneEn   = 4'b0001;
          plan.wrEn     = 1'b1;
          plan.nextSp   = regEnd;
          plan.spWrite  = 1'b1;
        end else if (sp > regStart && sp <= regEnd) begin
          plan.lanes[0] = spDec[AddrWidth-1:0];
          plan.laneEn   = 4'b0001;
          plan.wrEn     = 1'b1;
          plan.nextSp   = spDec;
          plan.spWrite  = 1'b1;
        end else begin
          plan.status = stOverflow;  // Stack full, nothing written
        end
      end
      opPop: begin
        plan.spWrite = 1'b1;
        if (sp >= regStart && sp < regEnd) begin
          plan.lanes[0] = sp[AddrWidth-1:0];
          plan.laneEn   = 4'b0001;
          plan.nextSp   = sp + 32'd1;
        end else if (sp == regEnd) begin  // Last item
          plan.lanes[0] = regEnd[AddrWidth-1:0];
          plan.laneEn   = 4'b0001;
          plan.nextSp   = EmptySp;
        end else begin
          plan.nextSp = EmptySp;
          plan.status = stUnderflow;
        end
      end
      opLoad, opStore: begin
        case (req.size)
          size2:   plan.laneEn = 4'b0011;
          size4:   plan.laneEn = 4'b1111;
          default: plan.laneEn = 4'b0001;
        endcase
        plan.wrEn = (req.op == opStore);
      end
      default: ;
    endcase
  end

  always_comb begin
    lanesClash = 1'b0;
    for (int i = 0; i < 4; i++) begin
      for (int j = i + 1; j < 4; j++) begin
        if (plan.laneEn[i] && plan.laneEn[j] && plan.lanes[i] == plan.lanes[j]) begin
          lanesClash = 1'b1;
        end
      end
    end
  end

  // Two enabled lanes on one byte would make the write order matter
  always_comb begin
    assert (!lanesClash) else $error("memoryAddressHandler: duplicate lane address");
  end

endmodule

`default_nettype wire

// File: src/pointerBank.sv
`timescale 1ns/1ps
`default_nettype none

module pointerBank #(
  parameter logic [31:0] UserStackStart = memMapPkg::DefUserStackStart,
  parameter logic [31:0] UserStackEnd   = memMapPkg::DefUserStackEnd,
  parameter logic [31:0] PrivStackStart = memMapPkg::DefPrivStackStart,
  parameter logic [31:0] PrivStackEnd   = memMapPkg::DefPrivStackEnd
) (
  input  wire        clk,
  input  wire        rstN,
  input  wire        priv,
  output logic [31:0] sp,
  input  wire        spWrite,
  input  wire [31:0] nextSp
);

  import memMapPkg::*;

  logic [31:0] userSp;
  logic [31:0] privSp;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      userSp <= EmptySp;
      privSp <= EmptySp;
    end else if (spWrite) begin
      if (priv) privSp <= nextSp;
      else userSp <= nextSp;
    end
  end

  assign sp = priv ? privSp : userSp;

  // Handler rules must keep each pointer within its own region
  userSpInRegion: assert property (@(posedge clk) disable iff (!rstN)
    userSp == EmptySp || (userSp >= UserStackStart && userSp <= UserStackEnd))
    else $error("pointerBank: user SP out of region");

  privSpInRegion: assert property (@(posedge clk) disable iff (!rstN)
    privSp == EmptySp || (privSp >= PrivStackStart && privSp <= PrivStackEnd))
    else $error("pointerBank: privileged SP out of region");

endmodule

`default_nettype wire

// File: src/byteMemory.sv
`timescale 1ns/1ps
`default_nettype none

module byteMemory (
  input  wire                        clk,
  input  wire memMapPkg::addrT [3:0] laneAddr,
  input  wire [3:0]                  laneEn,
  input  wire                        wrEn,
  input  wire [31:0]                 wrData,
  output logic [31:0]                rdData
);

  import memMapPkg::*;

  logic [7:0] mem [MemDepth];

  always_ff @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (laneEn[k] && wrEn) mem[laneAddr[k]] <= wrData[8*k +: 8];  // Data byte k to lane k
      rdData[8*k +: 8] <= laneEn[k] ? mem[laneAddr[k]] : 8'h00;    // Idle lanes read zero
    end
  end

endmodule

`default_nettype wire

// File: src/accessEngine.sv
`timescale 1ns/1ps
`default_nettype none

module accessEngine #(
  parameter int RspDepth = 4
) (
  input  wire                           clk,
  input  wire                           rstN,
  input  wire                           reqValid,
  input  wire accessPkg::accessReqT     req,
  output logic                          reqPop,
  input  wire [$clog2(RspDepth+1)-1:0]  rspSlots,
  output logic                          rspPush,
  output accessPkg::accessRspT          rsp,
  input  wire accessPkg::addrPlanT      plan,
  output accessPkg::accessReqT          curReq,
  output logic                          spWrite,
  output logic [3:0]                    memEn,
  output logic                          memWr,
  input  wire [31:0]                    rdData
);

  import accessPkg::*;

  typedef enum logic {sIdle, sAccess} stateT;

  stateT  state;
  logic   rspPend;    // Response goes out this cycle
  statusT rspStatus;

  // A pending response still needs its slot
  assign reqPop = (state == sIdle) && reqValid && (int'(rspSlots) > int'(rspPend));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= sIdle;
      rspPend <= 1'b0;
    end else begin
      rspPend <= (state == sAccess);
      case (state)
        sIdle:   if (reqPop) state <= sAccess;
        default: state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reqPop) curReq <= req;
    if (state == sAccess) rspStatus <= plan.status;  // SP moves at this edge
  end

  assign spWrite = (state == sAccess) && plan.spWrite;
  assign memEn   = (state == sAccess) ? plan.laneEn : 4'b0000;
  assign memWr   = (state == sAccess) && plan.wrEn;
  assign rspPush = rspPend;

  always_comb begin
    rsp.op     = curReq.op;
    rsp.status = rspStatus;
    case (curReq.op)
      opPop:   rsp.data = {24'h0, rdData[7:0]};
      opLoad:  rsp.data = rdData;
      default: rsp.data = 32'h0;
    endcase
  end

  // Slot reserved at pop time is still free when the response lands
  slotOnPush: assert property (@(posedge clk) disable iff (!rstN)
    rspPush |-> rspSlots != '0)
    else $error("accessEngine: response pushed with no free slot");

endmodule

`default_nettype wire

// File: src/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
  parameter logic [31:0] UserStackStart = memMapPkg::DefUserStackStart,
  parameter logic [31:0] UserStackEnd   = memMapPkg::DefUserStackEnd,
  parameter logic [31:0] PrivStackStart = memMapPkg::DefPrivStackStart,
  parameter logic [31:0] PrivStackEnd   = memMapPkg::DefPrivStackEnd,
  parameter int          ReqDepth       = 4,
  parameter int          RspDepth       = 4
) (
  input  wire                       clk,
  input  wire                       rstN,
  input  wire                       reqValid,
  input  wire accessPkg::accessReqT req,
  output logic                      reqCredit,
  output logic                      rspValid,
  output accessPkg::accessRspT      rsp,
  input  wire                       rspCredit
);

  import accessPkg::*;

  accessReqT                     headReq;
  accessReqT                     curReq;
  logic                          headValid;
  logic                          reqPop;
  logic [$clog2(RspDepth+1)-1:0] rspSlots;
  logic                          rspPush;
  accessRspT                     engRsp;
  addrPlanT                      plan;
  logic [31:0]                   sp;
  logic                          spWrite;
  logic [3:0]                    memEn;
  logic                          memWr;
  logic [31:0]                   rdData;

  creditFifo #(.itemT(accessReqT), .Depth(ReqDepth), .Gated(1'b0)) reqQueue (
    .clk, .rstN,
    .pushValid(reqValid), .pushItem(req),
    .popReady(reqPop), .popValid(headValid), .popItem(headReq),
    .freeSlots(),
    .creditIn(1'b0), .creditOut(reqCredit)
  );

  creditFifo #(.itemT(accessRspT), .Depth(RspDepth), .Gated(1'b1)) rspQueue (
    .clk, .rstN,
    .pushValid(rspPush), .pushItem(engRsp),
    .popReady(1'b1), .popValid(rspValid), .popItem(rsp),  // Host always takes
    .freeSlots(rspSlots),
    .creditIn(rspCredit), .creditOut()
  );

  accessEngine #(.RspDepth(RspDepth)) engine (
    .clk, .rstN,
    .reqValid(headValid), .req(headReq), .reqPop,
    .rspSlots, .rspPush, .rsp(engRsp),
    .plan, .curReq, .spWrite, .memEn, .memWr, .rdData
  );

  memoryAddressHandler #(
    .UserStackStart(UserStackStart), .UserStackEnd(UserStackEnd),
    .PrivStackStart(PrivStackStart), .PrivStackEnd(PrivStackEnd)
  ) addrHandler (
    .req(curReq), .sp, .plan
  );

  pointerBank #(
    .UserStackStart(UserStackStart), .UserStackEnd(UserStackEnd),
    .PrivStackStart(PrivStackStart), .PrivStackEnd(PrivStackEnd)
  ) spBank (
    .clk, .rstN, .priv(curReq.priv), .sp, .spWrite, .nextSp(plan.nextSp)
  );

  byteMemory dataMem (
    .clk, .laneAddr(plan.lanes), .laneEn(memEn), .wrEn(memWr),
    .wrData(curReq.data), .rdData
  );

endmodule

`default_nettype wire

// File: test/tbMemSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemSubsystem;

  import memMapPkg::*;
  import accessPkg::*;

  localparam int          ReqDepth  = 4;
  localparam int          RspDepth  = 4;
  localparam logic [31:0] UserStart = DefUserStackStart;
  localparam logic [31:0] UserEnd   = DefUserStackEnd;
  localparam logic [31:0] PrivStart = DefPrivStackStart;
  localparam logic [31:0] PrivEnd   = DefPrivStackEnd;
  localparam int          Timeout   = 200;  // Cycles allowed per wait

  logic      clk;
  logic      rstN;
  logic      reqValid;
  accessReqT req;
  logic      reqCredit;
  logic      rspValid;
  accessRspT rsp;
  logic      rspCredit;

  logic [31:0] lfsr;
  logic [7:0]  modelMem [MemDepth];
  logic [31:0] modelUserSp;
  logic [31:0] modelPrivSp;
  accessRspT   expQ [$];     // Responses still owed, in order
  int          hostCredits;  // Request credits the host holds
  int          sentCount;
  int          grantedCount;
  int          rspCount;
  int          creditsBack;
  int          cycleCount;
  int          lastRspCycle;
  int          creditAhead;  // Extra response credits granted early
  bit          grantOn;

  memSubsystem #(
    .UserStackStart(UserStart), .UserStackEnd(UserEnd),
    .PrivStackStart(PrivStart), .PrivStackEnd(PrivEnd),
    .ReqDepth(ReqDepth), .RspDepth(RspDepth)
  ) dut0 (
    .clk, .rstN, .reqValid, .req, .reqCredit, .rspValid, .rsp, .rspCredit
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        outBit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      outBit = lfsr[0];
      lfsr   = lfsr >> 1;
      if (outBit) lfsr = lfsr ^ 32'ha300_0000;
      val = {val[30:0], outBit};
    end
    return val;
  endfunction

  function automatic sizeT randSize();
    case (2'(randBits(2)))
      2'd0:    return size1;
      2'd1:    return size2;
      default: return size4;
    endcase
  endfunction

  function automatic int byteCount(input sizeT s);
    case (s)
      size2:   return 2;
      size4:   return 4;
      default: return 1;
    endcase
  endfunction

  function automatic int wrapAddr(input addrT base, input int k);
    return (int'(base) - k + MemDepth) % MemDepth;
  endfunction

  function automatic accessReqT makeReq(input opT op, input sizeT size, input logic priv,
                                        input addrT addr, input logic [31:0] data);
    accessReqT r;
    r.op   = op;
    r.size = size;
    r.priv = priv;
    r.addr = addr;
    r.data = data;
    return r;
  endfunction

  function automatic accessReqT randomReq();
    accessReqT r;
    case (2'(randBits(2)))
      2'd0:    r.op = opPush;
      2'd1:    r.op = opPop;
      2'd2:    r.op = opLoad;
      default: r.op = opStore;
    endcase
    r.size = randSize();
    r.priv = 1'(randBits(1));
    r.addr = addrT'(randBits(AddrWidth));
    r.data = randBits(32);
    return r;
  endfunction

  // Reference model applies one request and returns its response
  function automatic accessRspT applyModel(input accessReqT r);
    accessRspT   e;
    logic [31:0] sp;
    logic [31:0] lo;
    logic [31:0] hi;
    e.op     = r.op;
    e.status = stOk;
    e.data   = '0;
    sp = r.priv ? modelPrivSp : modelUserSp;
    lo = r.priv ? PrivStart : UserStart;
    hi = r.priv ? PrivEnd : UserEnd;
    case (r.op)
      opStore: begin
        for (int k = 0; k < byteCount(r.size); k++) begin
          modelMem[wrapAddr(r.addr, k)] = r.data[8*k +: 8];
        end
      end
      opLoad: begin
        for (int k = 0; k < byteCount(r.size); k++) begin
          e.data[8*k +: 8] = modelMem[wrapAddr(r.addr, k)];
        end
      end
      opPush: begin
        if (sp == EmptySp) begin
          modelMem[hi[AddrWidth-1:0]] = r.data[7:0];
          sp = hi;
        end else if (sp > lo && sp <= hi) begin
          sp = sp - 32'd1;
          modelMem[sp[AddrWidth-1:0]] = r.data[7:0];
        end else begin
          e.status = stOverflow;  // Full stack keeps its SP
        end
      end
      opPop: begin
        if (sp >= lo && sp < hi) begin
          e.data = {24'h0, modelMem[sp[AddrWidth-1:0]]};
          sp     = sp + 32'd1;
        end else if (sp == hi) begin
          e.data = {24'h0, modelMem[hi[AddrWidth-1:0]]};
          sp     = EmptySp;
        end else begin
          e.status = stUnderflow;
          sp       = EmptySp;
        end
      end
      default: ;
    endcase
    if (r.priv) modelPrivSp = sp;
    else modelUserSp = sp;
    return e;
  endfunction

  task automatic stopWithError(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic checkRsp(input accessRspT got, input accessRspT exp);
    if (got !== exp) begin
      stopWithError($sformatf("[ERROR] %0t rsp: got op=%0d status=%0d data=%h, expected %s",
                              $time, got.op, got.status, got.data,
                              $sformatf("op=%0d status=%0d data=%h",
                                        exp.op, exp.status, exp.data)));
    end
  endtask

  task automatic checkCreditCount(input string name, input int got, input int exp);
    if (got != exp) begin
      stopWithError($sformatf("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkIdle(input logic gotRspValid, input logic gotReqCredit);
    if (gotRspValid !== 1'b0) begin
      stopWithError($sformatf("[ERROR] %0t rspValid: got %b, expected 0", $time, gotRspValid));
    end
    if (gotReqCredit !== 1'b0) begin
      stopWithError($sformatf("[ERROR] %0t reqCredit: got %b, expected 0", $time, gotReqCredit));
    end
  endtask

  // One clock of host activity with optional request and credit grant
  task automatic advance(input bit send, input accessReqT r);
    logic give;
    @(posedge clk);
    cycleCount++;
    reqValid <= send;
    req      <= r;
    if (send) begin
      expQ.push_back(applyModel(r));
      hostCredits--;
      sentCount++;
    end
    give = 1'b0;
    if (grantOn && grantedCount < sentCount + creditAhead) give = (randBits(1) != 0);
    if (give) grantedCount++;
    rspCredit <= give;
  endtask

  task automatic sendReq(input accessReqT r);
    int waited;
    waited = 0;
    while (hostCredits == 0) begin
      advance(1'b0, '0);
      waited++;
      if (waited > Timeout) stopWithError("Timed out waiting for a request credit");
    end
    advance(1'b1, r);
    repeat (randBits(2)) advance(1'b0, '0);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (expQ.size() != 0) begin
      advance(1'b0, '0);
      waited++;
      if (waited > Timeout) stopWithError("Timed out waiting for outstanding responses");
    end
  endtask

  // Response and credit monitor sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (rstN) begin
        if (reqCredit) begin
          hostCredits++;
          creditsBack++;
        end
        if (rspValid) begin
          if (expQ.size() == 0) stopWithError("Response arrived with no request outstanding");
          else begin
            checkRsp(rsp, expQ.pop_front());
            rspCount++;
            lastRspCycle = cycleCount;
          end
        end
      end
    end
  end

  initial begin
    int   rspBefore;
    int   sentBefore;
    int   sendCycle;
    int   waited;
    addrT a;
    lfsr         = 32'hb40c_031d;
    rstN         = 1'b0;
    reqValid     = 1'b0;
    req          = '0;
    rspCredit    = 1'b0;
    hostCredits  = ReqDepth;
    sentCount    = 0;
    grantedCount = 0;
    rspCount     = 0;
    creditsBack  = 0;
    cycleCount   = 0;
    lastRspCycle = 0;
    creditAhead  = 0;
    grantOn      = 1'b0;
    modelUserSp  = EmptySp;
    modelPrivSp  = EmptySp;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    // Quiet outputs with no traffic
    repeat (20) begin
      advance(1'b0, '0);
      @(negedge clk);
      checkIdle(rspValid, reqCredit);
    end

    // Single request into empty queues, credit already granted
    grantOn     = 1'b1;
    creditAhead = 1;
    waited      = 0;
    while (grantedCount < sentCount + 1) begin
      advance(1'b0, '0);
      waited++;
      if (waited > Timeout) stopWithError("Timed out granting an early response credit");
    end
    creditAhead = 0;
    advance(1'b0, '0);
    advance(1'b1, makeReq(opStore, size1, 1'b0, addrT'(0), 32'h0));
    sendCycle = cycleCount;
    drain();
    checkCreditCount("response latency in cycles", lastRspCycle - sendCycle, 4);

    // Fill every byte so later loads read known data
    for (int j = 0; j < MemDepth / 4; j++) begin
      sendReq(makeReq(opStore, size4, 1'b0, addrT'(4 * j + 3), randBits(32)));
    end
    for (int i = 0; i < 60; i++) begin
      a = (randBits(1) != 0) ? addrT'(randBits(2)) : addrT'(randBits(AddrWidth));  // Wrap at zero
      sendReq(makeReq(opStore, randSize(), 1'b0, a, randBits(32)));
      sendReq(makeReq(opLoad, randSize(), 1'b0, a, 32'h0));
    end
    drain();

    // Stack underflow, overflow and independence
    sendReq(makeReq(opPop, size1, 1'b0, '0, 32'h0));
    sendReq(makeReq(opPop, size1, 1'b1, '0, 32'h0));
    repeat (3) sendReq(makeReq(opPush, size1, 1'b0, '0, randBits(32)));
    repeat (7) sendReq(makeReq(opPush, size1, 1'b1, '0, randBits(32)));  // Last overflows
    repeat (4) sendReq(makeReq(opPush, size1, 1'b0, '0, randBits(32)));
    repeat (7) sendReq(makeReq(opPop, size1, 1'b0, '0, 32'h0));
    repeat (7) sendReq(makeReq(opPop, size1, 1'b1, '0, 32'h0));
    for (int i = 0; i < 60; i++) begin
      sendReq(makeReq((randBits(1) != 0) ? opPush : opPop, size1, 1'(randBits(1)), '0,
                      randBits(32)));
    end
    drain();

    // Back-pressure with response credits withheld
    grantOn    = 1'b0;
    rspBefore  = rspCount;
    sentBefore = sentCount;
    repeat (60) begin
      if (hostCredits > 0) advance(1'b1, randomReq());
      else advance(1'b0, '0);
    end
    checkCreditCount("requests accepted while blocked", sentCount - sentBefore,
                     ReqDepth + RspDepth);
    checkCreditCount("responses while blocked", rspCount - rspBefore, 0);
    checkCreditCount("host credits while blocked", hostCredits, 0);
    grantOn = 1'b1;
    drain();

    // Credit totals once traffic is gone
    repeat (10) advance(1'b0, '0);
    @(negedge clk);
    checkIdle(rspValid, reqCredit);
    checkCreditCount("request credits returned", creditsBack, sentCount);
    checkCreditCount("host credits after drain", hostCredits, ReqDepth);
    checkCreditCount("responses vs credits granted", rspCount, grantedCount);
    checkCreditCount("responses vs requests", rspCount, sentCount);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/memMapPkg.sv
src/accessPkg.sv
src/creditFifo.sv
src/memoryAddressHandler.sv
src/pointerBank.sv
src/byteMemory.sv
src/accessEngine.sv
src/memSubsystem.sv
test/tbMemSubsystem.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= tbMemSubsystem
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# A $fatal in the testbench gives a nonzero exit status
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
